// File: logic/gomoku_defs.svh
`ifndef GOMOKU_DEFS_SVH
`define GOMOKU_DEFS_SVH

// cells along one edge of the square board
`define GOMOKU_BOARD_N 15

// stones of one colour in an unbroken line that end the game
`define GOMOKU_WIN_LEN 5

// wide enough for 0 to 15, so a row or column of 15 can arrive and be refused
`define GOMOKU_COORD_W 4

// edges after an accepted strobe during which new strobes are refused
// the board write and the win scan have both settled once it runs out
`define GOMOKU_MOVE_GAP 3

`endif

// File: logic/board_pkg.sv
`include "gomoku_defs.svh"

package board_pkg;

    //////////////////////////////////////////////////
    // cell contents
    //////////////////////////////////////////////////

    // black and white keep the 0 and 1 codes of the older checker, so empty is 2
    typedef enum logic [1:0] {
        cell_empty = 2'd2,
        cell_black = 2'd0, // black always opens the game
        cell_white = 2'd1
    } cell_t;

    //////////////////////////////////////////////////
    // positions and the board
    //////////////////////////////////////////////////

    typedef logic [`GOMOKU_COORD_W-1:0] coord_t; // one row or column number

    // row-major, so cell (r, c) is element r * 15 + c
    typedef cell_t [`GOMOKU_BOARD_N*`GOMOKU_BOARD_N-1:0] board_t;

endpackage

// File: logic/game_pkg.sv
`include "gomoku_defs.svh"

package game_pkg;

    // a request as it comes in from outside, colour is not part of it
    typedef struct packed {
        board_pkg::coord_t row;
        board_pkg::coord_t col;
    } move_t;

    // an accepted move with the colour of the side that played it
    typedef struct packed {
        board_pkg::coord_t row;
        board_pkg::coord_t col;
        board_pkg::cell_t  stone;
    } place_t;

    // a refused move carries the first of busy, over, range and occupied that applies
    typedef enum logic [2:0] {
        rej_none     = 3'd0,
        rej_range    = 3'd1, // row or column is 15
        rej_occupied = 3'd2,
        rej_over     = 3'd3, // somebody has already won
        rej_busy     = 3'd4  // an earlier move is still in flight
    } reject_t;

    // winner is only meaningful once win is set
    typedef struct packed {
        logic             win;
        board_pkg::cell_t winner;
    } result_t;

endpackage

// File: logic/move_checker.sv
`timescale 1ns/1ps
`include "gomoku_defs.svh"

module move_checker (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_move_valid,
    input  game_pkg::move_t     i_move,
    input  board_pkg::board_t   i_board,
    input  logic                i_game_over,
    output logic                o_place_valid,
    output game_pkg::place_t    o_place,
    output logic                o_reject_valid,
    output game_pkg::reject_t   o_reject_reason,
    output board_pkg::cell_t    o_turn
);
    import board_pkg::*;
    import game_pkg::*;

    localparam int     CELLS   = `GOMOKU_BOARD_N * `GOMOKU_BOARD_N;
    localparam int     IDX_W   = $clog2(CELLS);
    localparam int     GAP_W   = $clog2(`GOMOKU_MOVE_GAP + 1);
    localparam coord_t BOARD_N = coord_t'(`GOMOKU_BOARD_N);

    logic             pend_valid; // strobe captured at the sampling edge
    move_t            pend_move;
    logic [GAP_W-1:0] busy_cnt;
    logic             in_range;
    logic [IDX_W-1:0] cell_idx;
    reject_t          reason;
    logic             accept;

    //////////////////////////////////////////////////
    // capture stage
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= i_move_valid;
        end
    end

    //////////////////////////////////////////////////
    // legality check against the stored board
    //////////////////////////////////////////////////

    assign in_range = (pend_move.row < BOARD_N) && (pend_move.col < BOARD_N);

    // a refused coordinate would point past the last cell, so look at cell 0 instead
    assign cell_idx = in_range ?
        IDX_W'(pend_move.row) * IDX_W'(BOARD_N) + IDX_W'(pend_move.col) : '0;

    always_comb begin
        if (busy_cnt != '0) begin
            reason = rej_busy;
        end else if (i_game_over) begin
            reason = rej_over;
        end else if (!in_range) begin
            reason = rej_range;
        end else if (i_board[cell_idx] != cell_empty) begin
            reason = rej_occupied;
        end else begin
            reason = rej_none;
        end
    end

    assign accept = pend_valid && (reason == rej_none);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_place_valid  <= 1'b0;
            o_reject_valid <= 1'b0;
            o_turn         <= cell_black;
            busy_cnt       <= '0;
        end else begin
            o_place_valid  <= accept;
            o_reject_valid <= pend_valid && !accept;
            if (accept) begin
                o_turn   <= (o_turn == cell_black) ? cell_white : cell_black;
                busy_cnt <= GAP_W'(`GOMOKU_MOVE_GAP); // covers the next three strobes
            end else if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        pend_move       <= i_move;
        o_place.row     <= pend_move.row;
        o_place.col     <= pend_move.col;
        o_place.stone   <= o_turn; // colour before the toggle
        o_reject_reason <= reason;
    end

    a_one_outcome: assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_place_valid && o_reject_valid));

    a_stone_set: assert property (@(posedge i_clk) disable iff (i_reset)
        o_place_valid |-> (o_place.stone != cell_empty));

endmodule

// File: logic/board_store.sv
`timescale 1ns/1ps
`include "gomoku_defs.svh"

module board_store (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_place_valid,
    input  game_pkg::place_t    i_place,
    output board_pkg::board_t   o_board,
    output logic                o_update_valid,
    output board_pkg::cell_t    o_update_stone
);
    import board_pkg::*;

    localparam int CELLS = `GOMOKU_BOARD_N * `GOMOKU_BOARD_N;
    localparam int IDX_W = $clog2(CELLS);

    logic [IDX_W-1:0] wr_idx;

    // row-major position of the incoming stone
    assign wr_idx = IDX_W'(i_place.row) * IDX_W'(`GOMOKU_BOARD_N) + IDX_W'(i_place.col);

    //////////////////////////////////////////////////
    // board cells
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < CELLS; i++) begin
                o_board[i] <= cell_empty;
            end
        end else if (i_place_valid) begin
            o_board[wr_idx] <= i_place.stone;
        end
    end

    //////////////////////////////////////////////////
    // update notice for the detector
    //////////////////////////////////////////////////

    // the strobe goes out together with the new cell
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_update_valid <= 1'b0;
        end else begin
            o_update_valid <= i_place_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_update_stone <= i_place.stone;
    end

    // the checker looked at this cell two edges earlier and nothing else may have filled it
    a_write_empty: assert property (@(posedge i_clk) disable iff (i_reset)
        i_place_valid |-> (wr_idx < IDX_W'(CELLS)) && (o_board[wr_idx] == cell_empty));

endmodule

// File: logic/five_detector.sv
`timescale 1ns/1ps
`include "gomoku_defs.svh"

module five_detector (
    input  logic                i_clk,
    input  logic                i_reset,
    input  board_pkg::board_t   i_board,
    input  logic                i_update_valid,
    input  board_pkg::cell_t    i_update_stone,
    output logic                o_win_valid,
    output game_pkg::result_t   o_result,
    output logic                o_game_over
);
    import board_pkg::*;

    localparam int N     = `GOMOKU_BOARD_N;
    localparam int L     = `GOMOKU_WIN_LEN;
    localparam int IDX_W = $clog2(N * N);

    logic line_found;

    // true when L cells starting at (r, c) and stepping by (dr, dc) all hold stone
    // callers keep the whole window inside the board
    function automatic logic line_at(
        input board_t b,
        input cell_t  stone,
        input int     r,
        input int     c,
        input int     dr,
        input int     dc
    );
        logic hit;
        hit = 1'b1;
        for (int k = 0; k < L; k++) begin
            hit &= (b[IDX_W'((r + k * dr) * N + c + k * dc)] == stone);
        end
        return hit;
    endfunction

    //////////////////////////////////////////////////
    // window scan over the whole board
    //////////////////////////////////////////////////

    always_comb begin
        line_found = 1'b0;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                if (c <= N - L) begin
                    line_found |= line_at(i_board, i_update_stone, r, c, 0, 1); // across
                end
                if (r <= N - L) begin
                    line_found |= line_at(i_board, i_update_stone, r, c, 1, 0); // down
                end
                if (r <= N - L && c <= N - L) begin
                    line_found |= line_at(i_board, i_update_stone, r, c, 1, 1);
                end
                // down-left windows start at column 4 or right of it
                if (r <= N - L && c >= L - 1) begin
                    line_found |= line_at(i_board, i_update_stone, r, c, 1, -1);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // result and game-over latch
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_win_valid     <= 1'b0;
            o_game_over     <= 1'b0;
            o_result.win    <= 1'b0;
            o_result.winner <= cell_empty;
        end else begin
            o_win_valid <= i_update_valid && line_found; // one cycle per winning move
            if (i_update_valid && line_found) begin
                o_game_over     <= 1'b1; // held until reset
                o_result.win    <= 1'b1;
                o_result.winner <= i_update_stone;
            end
        end
    end

    // a second win could only come from a move the checker let through after game over
    a_single_win: assert property (@(posedge i_clk) disable iff (i_reset)
        o_win_valid |-> !$past(o_game_over));

endmodule

// File: logic/gomoku_core.sv
`timescale 1ns/1ps
`include "gomoku_defs.svh"

module gomoku_core (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_move_valid,
    input  game_pkg::move_t     i_move,
    output logic                o_reject_valid,
    output game_pkg::reject_t   o_reject_reason,
    output board_pkg::cell_t    o_turn,
    output board_pkg::board_t   o_board,
    output logic                o_win_valid,
    output game_pkg::result_t   o_result,
    output logic                o_game_over
);
    import board_pkg::*;
    import game_pkg::*;

    logic   place_valid;
    place_t place;
    logic   update_valid;
    cell_t  update_stone;

    // the board and the game-over level go out and loop back into the checker
    move_checker u_move_checker (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_move_valid    (i_move_valid),
        .i_move          (i_move),
        .i_board         (o_board),
        .i_game_over     (o_game_over),
        .o_place_valid   (place_valid),
        .o_place         (place),
        .o_reject_valid  (o_reject_valid),
        .o_reject_reason (o_reject_reason),
        .o_turn          (o_turn)
    );

    board_store u_board_store (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_place_valid  (place_valid),
        .i_place        (place),
        .o_board        (o_board),
        .o_update_valid (update_valid),
        .o_update_stone (update_stone)
    );

    five_detector u_five_detector (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_board        (o_board),
        .i_update_valid (update_valid),
        .i_update_stone (update_stone),
        .o_win_valid    (o_win_valid),
        .o_result       (o_result),
        .o_game_over    (o_game_over)
    );

endmodule

// File: testbench/gomoku_core_tb.sv
`timescale 1ns/1ps
`include "gomoku_defs.svh"

module gomoku_core_tb;
    import board_pkg::*;
    import game_pkg::*;

    localparam int         N_SIDE     = `GOMOKU_BOARD_N;
    localparam time        CLK_PERIOD = 40ns;
    localparam int         RST_CYCLES = 8;
    localparam logic [3:0] GAP_RANDOM = 4'hf; // idle cycles come from $urandom

    // one line of the stimulus table, its name sits at the same place in name_q
    typedef struct packed {
        logic       rst;    // reset the game before this move
        coord_t     row;
        coord_t     col;
        logic [3:0] gap;    // idle cycles before the strobe
        reject_t    reason;
        cell_t      turn;   // turn expected once the move is taken or refused
        logic       win;
        cell_t      winner;
    } entry_t;

    logic      i_clk;
    logic      i_reset;
    logic      i_move_valid;
    move_t     i_move;
    logic      o_reject_valid;
    reject_t   o_reject_reason;
    cell_t     o_turn;
    board_t    o_board;
    logic      o_win_valid;
    result_t   o_result;
    logic      o_game_over;

    entry_t    stim_q[$];
    string     name_q[$];
    board_t    model;    // board as it should look after the last driven move
    cell_t     cur_turn; // colour of the next accepted stone
    int        errors;

    gomoku_core i_dut (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_move_valid    (i_move_valid),
        .i_move          (i_move),
        .o_reject_valid  (o_reject_valid),
        .o_reject_reason (o_reject_reason),
        .o_turn          (o_turn),
        .o_board         (o_board),
        .o_win_valid     (o_win_valid),
        .o_result        (o_result),
        .o_game_over     (o_game_over)
    );

    initial i_clk = 1'b0;
    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic add_entry(input string name, input int rst, input int row, input int col,
                             input int gap, input reject_t reason, input cell_t turn,
                             input int win, input cell_t winner);
        entry_t e;
        e.rst    = (rst != 0);
        e.row    = coord_t'(row);
        e.col    = coord_t'(col);
        e.gap    = (gap < 0) ? GAP_RANDOM : 4'(gap);
        e.reason = reason;
        e.turn   = turn;
        e.win    = (win != 0);
        e.winner = winner;
        stim_q.push_back(e);
        name_q.push_back(name);
    endtask

    task automatic report_mismatch(input string test, input string item,
                                   input logic [$bits(board_t)-1:0] exp,
                                   input logic [$bits(board_t)-1:0] act);
        errors++;
        $display("FAILED %s %s: expected %0h, actual %0h", test, item, exp, act);
    endtask

    task automatic apply_reset();
        i_reset      = 1'b1;
        i_move_valid = 1'b0;
        repeat (RST_CYCLES) @(posedge i_clk);
        #2;
        i_reset = 1'b0;
        for (int i = 0; i < N_SIDE * N_SIDE; i++) begin
            model[i] = cell_empty;
        end
        cur_turn = cell_black;
    endtask

    // starts just before the sampling edge and follows the move to N+3
    task automatic check_entry(input int idx, input board_t exp_board);
        entry_t e;
        string  name;
        e    = stim_q[idx];
        name = name_q[idx];
        @(posedge i_clk);
        @(posedge i_clk);
        #2;
        if (o_reject_valid !== (e.reason != rej_none)) begin
            report_mismatch(name, "reject valid", e.reason != rej_none, o_reject_valid);
        end
        if (o_reject_reason !== e.reason) begin
            report_mismatch(name, "reject reason", e.reason, o_reject_reason);
        end
        if (o_turn !== e.turn) begin
            report_mismatch(name, "turn", e.turn, o_turn);
        end
        @(posedge i_clk);
        #2;
        if (o_board !== exp_board) begin
            report_mismatch(name, "board", exp_board, o_board);
        end
        @(posedge i_clk);
        #2;
        if (o_win_valid !== e.win) begin
            report_mismatch(name, "win valid", e.win, o_win_valid);
        end
        if (e.win && (o_result !== {1'b1, e.winner})) begin
            report_mismatch(name, "result", {1'b1, e.winner}, o_result);
        end
        if (e.win && (o_game_over !== 1'b1)) begin
            report_mismatch(name, "game over", 1'b1, o_game_over);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////

    task automatic fill_table();
        // black takes row 7 while white follows on row 8
        add_entry("accept_black_1", 0, 7, 3, -1, rej_none, cell_white, 0, cell_empty);
        add_entry("accept_white_1", 0, 8, 3, -1, rej_none, cell_black, 0, cell_empty);
        add_entry("accept_black_2", 0, 7, 4, -1, rej_none, cell_white, 0, cell_empty);
        add_entry("range_row", 0, 15, 2, -1, rej_range, cell_white, 0, cell_empty);
        add_entry("range_col", 0, 3, 15, -1, rej_range, cell_white, 0, cell_empty);
        add_entry("occupied_cell", 0, 7, 3, -1, rej_occupied, cell_white, 0, cell_empty);
        add_entry("accept_white_2", 0, 8, 4, -1, rej_none, cell_black, 0, cell_empty);
        add_entry("accept_black_3", 0, 7, 5, -1, rej_none, cell_white, 0, cell_empty);
        add_entry("busy_strobe", 0, 0, 0, 0, rej_busy, cell_white, 0, cell_empty);
        add_entry("accept_white_3", 0, 8, 5, -1, rej_none, cell_black, 0, cell_empty);
        add_entry("black_four", 0, 7, 6, -1, rej_none, cell_white, 0, cell_empty);
        add_entry("white_four", 0, 8, 6, -1, rej_none, cell_black, 0, cell_empty);
        add_entry("black_row_five", 0, 7, 7, -1, rej_none, cell_white, 1, cell_black);
        add_entry("over_white", 0, 8, 7, -1, rej_over, cell_white, 0, cell_empty);
        add_entry("over_range", 0, 15, 15, -1, rej_over, cell_white, 0, cell_empty);

        // white fills column 0 down to the bottom edge
        add_entry("reset_black_first", 1, 0, 2, -1, rej_none, cell_white, 0, cell_empty);
        add_entry("col_white_1", 0, 10, 0, -1, rej_none, cell_black, 0, cell_empty);
        add_entry("col_black_2", 0, 2, 2, -1, rej_none, cell_white, 0, cell_empty);
        add_entry("col_white_2", 0, 11, 0, -1, rej_none, cell_black, 0, cell_empty);
        add_entry("col_black_3", 0, 4, 2, -1, rej_none, cell_white, 0, cell_empty);
        add_entry("col_white_3", 0, 12, 0, -1, rej_none, cell_black, 0, cell_empty);
        add_entry("col_black_4", 0, 6, 2, -1, rej_none, cell_white, 0, cell_empty);
        add_entry("col_white_4", 0, 13, 0, -1, rej_none, cell_black, 0, cell_empty);
        add_entry("col_black_5", 0, 8, 2, -1, rej_none, cell_white, 0, cell_empty);
        add_entry("white_col_five", 0, 14, 0, -1, rej_none, cell_black, 1, cell_white);

        // black leaves a hole at column 4, white runs down-right into the corner
        add_entry("gap_black_1", 1, 0, 0, -1, rej_none, cell_white, 0, cell_empty);
        add_entry("diag_white_1", 0, 10, 10, -1, rej_none, cell_black, 0, cell_empty);
        add_entry("gap_black_2", 0, 0, 1, -1, rej_none, cell_white, 0, cell_empty);
        add_entry("diag_white_2", 0, 11, 11, -1, rej_none, cell_black, 0, cell_empty);
        add_entry("gap_black_3", 0, 0, 2, -1, rej_none, cell_white, 0, cell_empty);
        add_entry("diag_white_3", 0, 12, 12, -1, rej_none, cell_black, 0, cell_empty);
        add_entry("gap_black_4", 0, 0, 3, -1, rej_none, cell_white, 0, cell_empty);
        add_entry("diag_white_4", 0, 13, 13, -1, rej_none, cell_black, 0, cell_empty);
        add_entry("gap_black_five", 0, 0, 5, -1, rej_none, cell_white, 0, cell_empty);
        add_entry("white_diag_five", 0, 14, 14, -1, rej_none, cell_black, 1, cell_white);

        // black runs down-left from the top right corner
        add_entry("anti_black_1", 1, 0, 14, -1, rej_none, cell_white, 0, cell_empty);
        add_entry("edge_white_1", 0, 14, 0, -1, rej_none, cell_black, 0, cell_empty);
        add_entry("anti_black_2", 0, 1, 13, -1, rej_none, cell_white, 0, cell_empty);
        add_entry("edge_white_2", 0, 14, 2, -1, rej_none, cell_black, 0, cell_empty);
        add_entry("anti_black_3", 0, 2, 12, -1, rej_none, cell_white, 0, cell_empty);
        add_entry("edge_white_3", 0, 14, 4, -1, rej_none, cell_black, 0, cell_empty);
        add_entry("anti_black_4", 0, 3, 11, -1, rej_none, cell_white, 0, cell_empty);
        add_entry("edge_white_4", 0, 14, 6, -1, rej_none, cell_black, 0, cell_empty);
        add_entry("black_anti_five", 0, 4, 10, -1, rej_none, cell_white, 1, cell_black);
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        int gap;
        i_reset      = 1'b1;
        i_move_valid = 1'b0;
        i_move       = '0;
        errors       = 0;
        void'($urandom(32'h7ec7c39f));
        fill_table();
        apply_reset();
        for (int i = 0; i < stim_q.size(); i++) begin
            if (stim_q[i].rst) begin
                #2;
                i_move_valid = 1'b0;
                repeat (4) @(posedge i_clk); // lets the last move's checks finish
                #2;
                apply_reset();
            end else begin
                gap = (stim_q[i].gap == GAP_RANDOM) ? 3 + int'($urandom % 4) : int'(stim_q[i].gap);
                repeat (gap) begin
                    #2;
                    i_move_valid = 1'b0;
                    @(posedge i_clk);
                end
                #2;
            end
            if (stim_q[i].reason == rej_none) begin
                model[int'(stim_q[i].row) * N_SIDE + int'(stim_q[i].col)] = cur_turn;
                cur_turn = stim_q[i].turn;
            end
            fork
                automatic int     k    = i;
                automatic board_t snap = model;
                check_entry(k, snap);
            join_none
            i_move_valid = 1'b1;
            i_move.row   = stim_q[i].row;
            i_move.col   = stim_q[i].col;
            @(posedge i_clk);
        end
        #2;
        i_move_valid = 1'b0;
        repeat (4) @(posedge i_clk);
        $display("%0d table entries applied, %0d errors", stim_q.size(), errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #1;
        #(stim_q.size() * 10 * CLK_PERIOD);
        $display("timeout: the move table did not finish in time, %0d errors so far", errors);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: list.f
+incdir+logic
logic/board_pkg.sv
logic/game_pkg.sv
logic/move_checker.sv
logic/board_store.sv
logic/five_detector.sv
logic/gomoku_core.sv
testbench/gomoku_core_tb.sv

// File: Makefile
# Verilator build and run for the gomoku rule engine

VERILATOR ?= verilator
TB_TOP    ?= gomoku_core_tb
RTL_TOP   ?= gomoku_core
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TEST FAIL
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)

run: build
	./$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
